// ==== mem_pkg.sv ====
package mem_pkg;

	// Datapath and address width
	localparam int XLEN = 32;

	// One byte enable per byte lane of a word
	localparam int BE_W = XLEN / 8;

	// Instruction size, step of the sequential PC
	localparam logic [XLEN-1:0] PC_STEP = 'd4;

	// Memory operation issued to the load/store unit
	typedef enum logic [2:0] {
		LB,
		LBU,
		LH,
		LHU,
		LW,
		SB,
		SH,
		SW
	} ldst_type_t;

	// Tag of the requester that owns an L2 access
	typedef enum logic {
		SRC_FETCH,
		SRC_DATA
	} l2_src_e;

	// Exceptions reported with a completed memory operation
	typedef enum logic [1:0] {
		E_NONE,
		E_LD_MISALIGN,
		E_ST_MISALIGN
	} except_code_t;

endpackage

// ==== l2_chan_if.sv ====
interface l2_chan_if;
	import mem_pkg::*;

	// Request side, held stable from raise to transfer
	logic            req_valid;
	logic [XLEN-1:0] req_addr;
	logic            req_we;
	logic [BE_W-1:0] req_be;
	logic [XLEN-1:0] req_wdata;

	// Only high for the channel that owns the grant
	logic            req_rdy;

	// One-cycle answer pulse, never stalled
	logic            ans_valid;
	logic [XLEN-1:0] ans_rdata;

	modport requester (
		output req_valid,
		output req_addr,
		output req_we,
		output req_be,
		output req_wdata,
		input  req_rdy,
		input  ans_valid,
		input  ans_rdata
	);

	modport arbiter (
		input  req_valid,
		input  req_addr,
		input  req_we,
		input  req_be,
		input  req_wdata,
		output req_rdy,
		output ans_valid,
		output ans_rdata
	);

endinterface

// ==== ifetch_unit.sv ====
module ifetch_unit #(
	parameter logic [mem_pkg::XLEN-1:0] BOOT_PC = '0
) (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     flush_i,
	input  logic [mem_pkg::XLEN-1:0] flush_pc_i,
	output logic [mem_pkg::XLEN-1:0] ins_o,
	output logic [mem_pkg::XLEN-1:0] pc_o,
	output logic                     ins_valid_o,
	input  logic                     ins_ready_i,
	l2_chan_if.requester             ch
);
	import mem_pkg::*;

	// Program counter and address of the request in flight
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] req_addr_q;

	// Request raised, waiting for the arbiter
	logic req_valid_q;
	// Request transferred, answer not back yet
	logic pend_q;
	// Outstanding access belongs to a flushed stream
	logic stale_q;

	// Output buffer
	logic            buf_valid_q;
	logic [XLEN-1:0] buf_ins_q;
	logic [XLEN-1:0] buf_pc_q;

	logic req_done;
	logic ans_take;
	logic buf_free;
	logic issue;

	assign req_done = req_valid_q && ch.req_rdy;
	// Answers of a flushed stream never reach the buffer
	assign ans_take = ch.ans_valid && !stale_q && !flush_i;
	// Buffer empty, or drained this cycle
	assign buf_free = !buf_valid_q || ins_ready_i;
	assign issue    = !flush_i && !req_valid_q && !pend_q && buf_free;

	// Fetch is read only, whole word
	assign ch.req_valid = req_valid_q;
	assign ch.req_addr  = req_addr_q;
	assign ch.req_we    = 1'b0;
	assign ch.req_be    = '1;
	assign ch.req_wdata = '0;

	assign ins_o       = buf_ins_q;
	assign pc_o        = buf_pc_q;
	assign ins_valid_o = buf_valid_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pc_q        <= BOOT_PC;
			req_valid_q <= 1'b0;
			pend_q      <= 1'b0;
			stale_q     <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			// Handshake with the arbiter
			if (req_done) begin
				req_valid_q <= 1'b0;
			end else if (issue) begin
				req_valid_q <= 1'b1;
			end
			if (ch.ans_valid) begin
				pend_q <= 1'b0;
			end else if (req_done) begin
				pend_q <= 1'b1;
			end
			// Mark whatever is still outstanding after a flush
			if (flush_i) begin
				stale_q <= req_valid_q || (pend_q && !ch.ans_valid);
			end else if (ch.ans_valid) begin
				stale_q <= 1'b0;
			end
			// Buffer fill and drain
			if (flush_i) begin
				buf_valid_q <= 1'b0;
			end else if (ans_take) begin
				buf_valid_q <= 1'b1;
			end else if (ins_ready_i) begin
				buf_valid_q <= 1'b0;
			end
			// Redirect wins over sequential advance
			if (flush_i) begin
				pc_q <= flush_pc_i;
			end else if (ans_take) begin
				pc_q <= req_addr_q + PC_STEP;
			end
		end
	end

	// Payload, valid only under the flags above
	always_ff @(posedge clk_i) begin
		if (issue) begin
			req_addr_q <= pc_q;
		end
		if (ans_take) begin
			buf_ins_q <= ch.ans_rdata;
			buf_pc_q  <= req_addr_q;
		end
	end

endmodule

// ==== ldst_unit.sv ====
module ldst_unit (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     op_valid_i,
	output logic                     op_ready_o,
	input  mem_pkg::ldst_type_t      op_type_i,
	input  logic [mem_pkg::XLEN-1:0] op_addr_i,
	input  logic [mem_pkg::XLEN-1:0] op_wdata_i,
	output logic                     done_valid_o,
	input  logic                     done_ready_i,
	output logic [mem_pkg::XLEN-1:0] ld_data_o,
	output logic                     except_raised_o,
	output mem_pkg::except_code_t    except_code_o,
	l2_chan_if.requester             ch
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT,
		S_DONE
	} state_e;

	state_e state_q;

	// Registered operation
	ldst_type_t      type_q;
	logic [1:0]      off_q;
	logic [XLEN-1:0] addr_q;
	logic            we_q;
	logic [BE_W-1:0] be_q;
	logic [XLEN-1:0] wdata_q;

	// Result
	logic [XLEN-1:0] ld_data_q;
	logic            exc_q;
	except_code_t    code_q;

	logic            accept;
	logic            is_half;
	logic            is_word;
	logic            is_store;
	logic            misalign;
	logic [BE_W-1:0] be_d;
	logic [XLEN-1:0] wdata_d;
	logic [XLEN-1:0] lane;
	logic [XLEN-1:0] ext_d;

	assign accept = op_valid_i && (state_q == S_IDLE);

	// Decode of the incoming op
	always_comb begin
		is_half  = op_type_i inside {LH, LHU, SH};
		is_word  = op_type_i inside {LW, SW};
		is_store = op_type_i inside {SB, SH, SW};
		misalign = (is_half && op_addr_i[0]) || (is_word && (op_addr_i[1:0] != 2'b00));
		// Store data moved into its byte lanes
		case (op_type_i)
			SB: begin
				be_d    = 4'b0001 << op_addr_i[1:0];
				wdata_d = {{(XLEN-8){1'b0}}, op_wdata_i[7:0]} << {op_addr_i[1:0], 3'b000};
			end
			SH: begin
				be_d    = 4'b0011 << op_addr_i[1:0];
				wdata_d = {{(XLEN-16){1'b0}}, op_wdata_i[15:0]} << {op_addr_i[1:0], 3'b000};
			end
			default: begin
				be_d    = '1;
				wdata_d = op_wdata_i;
			end
		endcase
	end

	// Lane extraction and extension of load data
	always_comb begin
		lane = ch.ans_rdata >> {off_q, 3'b000};
		case (type_q)
			LB:      ext_d = {{(XLEN-8){lane[7]}}, lane[7:0]};
			LBU:     ext_d = {{(XLEN-8){1'b0}}, lane[7:0]};
			LH:      ext_d = {{(XLEN-16){lane[15]}}, lane[15:0]};
			LHU:     ext_d = {{(XLEN-16){1'b0}}, lane[15:0]};
			LW:      ext_d = lane;
			// Stores return zero
			default: ext_d = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			exc_q   <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (accept) begin
						// Misaligned ops skip the L2 entirely
						state_q <= misalign ? S_DONE : S_REQ;
						exc_q   <= misalign;
					end
				end
				S_REQ: begin
					if (ch.req_rdy) begin
						state_q <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (ch.ans_valid) begin
						state_q <= S_DONE;
					end
				end
				default: begin
					if (done_ready_i) begin
						state_q <= S_IDLE;
						exc_q   <= 1'b0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			type_q    <= op_type_i;
			off_q     <= op_addr_i[1:0];
			addr_q    <= {op_addr_i[XLEN-1:2], 2'b00};
			we_q      <= is_store;
			be_q      <= be_d;
			wdata_q   <= wdata_d;
			ld_data_q <= '0;
			if (!misalign) begin
				code_q <= E_NONE;
			end else begin
				code_q <= is_store ? E_ST_MISALIGN : E_LD_MISALIGN;
			end
		end
		if ((state_q == S_WAIT) && ch.ans_valid) begin
			ld_data_q <= ext_d;
		end
	end

	assign ch.req_valid = (state_q == S_REQ);
	assign ch.req_addr  = addr_q;
	assign ch.req_we    = we_q;
	assign ch.req_be    = be_q;
	assign ch.req_wdata = wdata_q;

	assign op_ready_o      = (state_q == S_IDLE);
	assign done_valid_o    = (state_q == S_DONE);
	assign ld_data_o       = ld_data_q;
	assign except_raised_o = exc_q;
	assign except_code_o   = code_q;

endmodule

// ==== l2_arbiter.sv ====
module l2_arbiter (
	input  logic                     clk_i,
	input  logic                     rst_i,
	l2_chan_if.arbiter               fetch_ch,
	l2_chan_if.arbiter               data_ch,
	output logic                     l2_req_valid_o,
	output logic [mem_pkg::XLEN-1:0] l2_req_addr_o,
	output logic                     l2_req_we_o,
	output logic [mem_pkg::BE_W-1:0] l2_req_be_o,
	output logic [mem_pkg::XLEN-1:0] l2_req_wdata_o,
	output mem_pkg::l2_src_e         l2_req_src_o,
	input  logic                     l2_req_rdy_i,
	input  logic                     l2_ans_valid_i,
	input  logic [mem_pkg::XLEN-1:0] l2_ans_rdata_i,
	input  mem_pkg::l2_src_e         l2_ans_src_i
);
	import mem_pkg::*;

	// Grant held while a request waits on the L2
	logic    lock_q;
	l2_src_e lock_src_q;
	l2_src_e sel;

	// Data side has priority unless a grant is locked
	always_comb begin
		if (lock_q) begin
			sel = lock_src_q;
		end else if (data_ch.req_valid) begin
			sel = SRC_DATA;
		end else begin
			sel = SRC_FETCH;
		end
	end

	// Request mux
	always_comb begin
		if (sel == SRC_DATA) begin
			l2_req_valid_o = data_ch.req_valid;
			l2_req_addr_o  = data_ch.req_addr;
			l2_req_we_o    = data_ch.req_we;
			l2_req_be_o    = data_ch.req_be;
			l2_req_wdata_o = data_ch.req_wdata;
		end else begin
			l2_req_valid_o = fetch_ch.req_valid;
			l2_req_addr_o  = fetch_ch.req_addr;
			l2_req_we_o    = fetch_ch.req_we;
			l2_req_be_o    = fetch_ch.req_be;
			l2_req_wdata_o = fetch_ch.req_wdata;
		end
	end

	assign l2_req_src_o = sel;

	// Ready reaches the granted channel only
	assign data_ch.req_rdy  = l2_req_rdy_i && (sel == SRC_DATA);
	assign fetch_ch.req_rdy = l2_req_rdy_i && (sel == SRC_FETCH);

	// Answers steered by their source tag
	assign data_ch.ans_valid  = l2_ans_valid_i && (l2_ans_src_i == SRC_DATA);
	assign fetch_ch.ans_valid = l2_ans_valid_i && (l2_ans_src_i == SRC_FETCH);
	assign data_ch.ans_rdata  = l2_ans_rdata_i;
	assign fetch_ch.ans_rdata = l2_ans_rdata_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			lock_q     <= 1'b0;
			lock_src_q <= SRC_FETCH;
		end else if (l2_req_valid_o && !l2_req_rdy_i) begin
			// Stalled, keep this owner until it transfers
			lock_q     <= 1'b1;
			lock_src_q <= sel;
		end else if (l2_req_valid_o) begin
			lock_q <= 1'b0;
		end
	end

endmodule

// ==== data_path_memory.sv ====
module data_path_memory #(
	parameter logic [mem_pkg::XLEN-1:0] BOOT_PC = '0
) (
	input  logic                     clk_i,
	input  logic                     rst_i,

	// Fetch redirect and instruction output
	input  logic                     flush_i,
	input  logic [mem_pkg::XLEN-1:0] flush_pc_i,
	output logic [mem_pkg::XLEN-1:0] ins_o,
	output logic [mem_pkg::XLEN-1:0] pc_o,
	output logic                     ins_valid_o,
	input  logic                     ins_ready_i,

	// Memory operations
	input  logic                     op_valid_i,
	output logic                     op_ready_o,
	input  mem_pkg::ldst_type_t      op_type_i,
	input  logic [mem_pkg::XLEN-1:0] op_addr_i,
	input  logic [mem_pkg::XLEN-1:0] op_wdata_i,
	output logic                     done_valid_o,
	input  logic                     done_ready_i,
	output logic [mem_pkg::XLEN-1:0] ld_data_o,
	output logic                     except_raised_o,
	output mem_pkg::except_code_t    except_code_o,

	// External L2 port
	output logic                     l2_req_valid_o,
	output logic [mem_pkg::XLEN-1:0] l2_req_addr_o,
	output logic                     l2_req_we_o,
	output logic [mem_pkg::BE_W-1:0] l2_req_be_o,
	output logic [mem_pkg::XLEN-1:0] l2_req_wdata_o,
	output mem_pkg::l2_src_e         l2_req_src_o,
	input  logic                     l2_req_rdy_i,
	input  logic                     l2_ans_valid_i,
	input  logic [mem_pkg::XLEN-1:0] l2_ans_rdata_i,
	input  mem_pkg::l2_src_e         l2_ans_src_i
);

	// One channel per requester into the arbiter
	l2_chan_if fetch_ch ();
	l2_chan_if data_ch ();

	ifetch_unit #(
		.BOOT_PC (BOOT_PC)
	) u_ifetch (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.flush_i     (flush_i),
		.flush_pc_i  (flush_pc_i),
		.ins_o       (ins_o),
		.pc_o        (pc_o),
		.ins_valid_o (ins_valid_o),
		.ins_ready_i (ins_ready_i),
		.ch          (fetch_ch.requester)
	);

	ldst_unit u_ldst (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.op_valid_i      (op_valid_i),
		.op_ready_o      (op_ready_o),
		.op_type_i       (op_type_i),
		.op_addr_i       (op_addr_i),
		.op_wdata_i      (op_wdata_i),
		.done_valid_o    (done_valid_o),
		.done_ready_i    (done_ready_i),
		.ld_data_o       (ld_data_o),
		.except_raised_o (except_raised_o),
		.except_code_o   (except_code_o),
		.ch              (data_ch.requester)
	);

	l2_arbiter u_arb (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.fetch_ch       (fetch_ch.arbiter),
		.data_ch        (data_ch.arbiter),
		.l2_req_valid_o (l2_req_valid_o),
		.l2_req_addr_o  (l2_req_addr_o),
		.l2_req_we_o    (l2_req_we_o),
		.l2_req_be_o    (l2_req_be_o),
		.l2_req_wdata_o (l2_req_wdata_o),
		.l2_req_src_o   (l2_req_src_o),
		.l2_req_rdy_i   (l2_req_rdy_i),
		.l2_ans_valid_i (l2_ans_valid_i),
		.l2_ans_rdata_i (l2_ans_rdata_i),
		.l2_ans_src_i   (l2_ans_src_i)
	);

endmodule

// ==== data_path_memory_chk.sv ====
module data_path_memory_chk (
	input logic                     clk_i,
	input logic                     rst_i,
	input logic                     l2_req_valid_o,
	input logic [mem_pkg::XLEN-1:0] l2_req_addr_o,
	input logic                     l2_req_we_o,
	input logic [mem_pkg::BE_W-1:0] l2_req_be_o,
	input logic [mem_pkg::XLEN-1:0] l2_req_wdata_o,
	input mem_pkg::l2_src_e         l2_req_src_o,
	input logic                     l2_req_rdy_i,
	input logic                     l2_ans_valid_i,
	input mem_pkg::l2_src_e         l2_ans_src_i,
	input logic                     done_valid_o,
	input logic                     done_ready_i
);
	import mem_pkg::*;

	// Fetch access transferred, answer still due
	logic fetch_out_q;
	logic fetch_xfer;

	assign fetch_xfer = l2_req_valid_o && l2_req_rdy_i && (l2_req_src_o == SRC_FETCH);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			fetch_out_q <= 1'b0;
		end else if (fetch_xfer) begin
			fetch_out_q <= 1'b1;
		end else if (l2_ans_valid_i && (l2_ans_src_i == SRC_FETCH)) begin
			fetch_out_q <= 1'b0;
		end
	end

	// Stalled request keeps all its fields
	req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		l2_req_valid_o && !l2_req_rdy_i |=> l2_req_valid_o && $stable(l2_req_addr_o)
			&& $stable(l2_req_we_o) && $stable(l2_req_be_o)
			&& $stable(l2_req_wdata_o) && $stable(l2_req_src_o))
		else $error("L2 request changed while stalled");

	// Quiet port right after reset
	reset_quiet: assert property (@(posedge clk_i) rst_i |=> !l2_req_valid_o)
		else $error("L2 request valid in the cycle after reset");

	done_held: assert property (@(posedge clk_i) disable iff (rst_i)
		done_valid_o && !done_ready_i |=> done_valid_o)
		else $error("done_valid_o dropped before done_ready_i");

	// One fetch access at a time
	fetch_single: assert property (@(posedge clk_i) disable iff (rst_i)
		fetch_xfer |-> !fetch_out_q)
		else $error("second fetch request before the answer");

endmodule

// ==== data_path_memory_tb.sv ====
module data_path_memory_tb;
	import mem_pkg::*;

	localparam logic [XLEN-1:0] BOOT  = 'h100;
	// Data region, well above any fetch address reached
	localparam logic [XLEN-1:0] DBASE = 'h1800;
	// 110 memory ops and 44 awaited instructions
	localparam int N_OPS = 154;
	localparam int MEM_W = 2048;

	logic            clk_i;
	logic            rst_i;
	logic            flush_i;
	logic [XLEN-1:0] flush_pc_i;
	logic [XLEN-1:0] ins_o;
	logic [XLEN-1:0] pc_o;
	logic            ins_valid_o;
	logic            ins_ready_i;
	logic            op_valid_i;
	logic            op_ready_o;
	ldst_type_t      op_type_i;
	logic [XLEN-1:0] op_addr_i;
	logic [XLEN-1:0] op_wdata_i;
	logic            done_valid_o;
	logic            done_ready_i;
	logic [XLEN-1:0] ld_data_o;
	logic            except_raised_o;
	except_code_t    except_code_o;
	logic            l2_req_valid_o;
	logic [XLEN-1:0] l2_req_addr_o;
	logic            l2_req_we_o;
	logic [BE_W-1:0] l2_req_be_o;
	logic [XLEN-1:0] l2_req_wdata_o;
	l2_src_e         l2_req_src_o;
	logic            l2_req_rdy_i;
	logic            l2_ans_valid_i;
	logic [XLEN-1:0] l2_ans_rdata_i;
	l2_src_e         l2_ans_src_i;

	integer seed;

	// L2 contents and the expected image of memory
	logic [XLEN-1:0] mem [MEM_W];
	logic [XLEN-1:0] ref_mem [MEM_W];

	// Answers waiting in the L2 model, in order
	logic [XLEN-1:0] ans_q [$];
	l2_src_e         src_q [$];
	int              due_q [$];
	int              cycle;
	int              last_due;

	// Expectations
	logic [XLEN-1:0] exp_pc;
	logic [XLEN-1:0] exp_data;
	except_code_t    exp_code;
	logic            dreq_pend;
	logic [XLEN-1:0] dreq_addr;
	logic            dreq_we;
	logic [BE_W-1:0] dreq_be;

	// Next fetch address, and one raised before a redirect
	logic [XLEN-1:0] fetch_addr;
	logic [XLEN-1:0] old_addr;
	logic            old_pend;

	int ins_count;
	int done_count;
	int checks;
	int errors;

	data_path_memory #(
		.BOOT_PC (BOOT)
	) u_dut (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.flush_i         (flush_i),
		.flush_pc_i      (flush_pc_i),
		.ins_o           (ins_o),
		.pc_o            (pc_o),
		.ins_valid_o     (ins_valid_o),
		.ins_ready_i     (ins_ready_i),
		.op_valid_i      (op_valid_i),
		.op_ready_o      (op_ready_o),
		.op_type_i       (op_type_i),
		.op_addr_i       (op_addr_i),
		.op_wdata_i      (op_wdata_i),
		.done_valid_o    (done_valid_o),
		.done_ready_i    (done_ready_i),
		.ld_data_o       (ld_data_o),
		.except_raised_o (except_raised_o),
		.except_code_o   (except_code_o),
		.l2_req_valid_o  (l2_req_valid_o),
		.l2_req_addr_o   (l2_req_addr_o),
		.l2_req_we_o     (l2_req_we_o),
		.l2_req_be_o     (l2_req_be_o),
		.l2_req_wdata_o  (l2_req_wdata_o),
		.l2_req_src_o    (l2_req_src_o),
		.l2_req_rdy_i    (l2_req_rdy_i),
		.l2_ans_valid_i  (l2_ans_valid_i),
		.l2_ans_rdata_i  (l2_ans_rdata_i),
		.l2_ans_src_i    (l2_ans_src_i)
	);

	bind data_path_memory data_path_memory_chk u_chk (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.l2_req_valid_o (l2_req_valid_o),
		.l2_req_addr_o  (l2_req_addr_o),
		.l2_req_we_o    (l2_req_we_o),
		.l2_req_be_o    (l2_req_be_o),
		.l2_req_wdata_o (l2_req_wdata_o),
		.l2_req_src_o   (l2_req_src_o),
		.l2_req_rdy_i   (l2_req_rdy_i),
		.l2_ans_valid_i (l2_ans_valid_i),
		.l2_ans_src_i   (l2_ans_src_i),
		.done_valid_o   (done_valid_o),
		.done_ready_i   (done_ready_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// Expected load result from the word in memory
	function automatic logic [XLEN-1:0] exp_load(logic [XLEN-1:0] word,
			logic [XLEN-1:0] addr, ldst_type_t t);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[{addr[1:0], 3'b000} +: 8];
		h = addr[1] ? word[31:16] : word[15:0];
		case (t)
			LB:      return {{(XLEN-8){b[7]}}, b};
			LBU:     return {{(XLEN-8){1'b0}}, b};
			LH:      return {{(XLEN-16){h[15]}}, h};
			LHU:     return {{(XLEN-16){1'b0}}, h};
			LW:      return word;
			default: return '0;
		endcase
	endfunction

	// Bytes moved by one access
	function automatic int access_size(ldst_type_t t);
		case (t)
			LH, LHU, SH: return 2;
			LW, SW:      return 4;
			default:     return 1;
		endcase
	endfunction

	// Loads read the whole word
	function automatic logic [BE_W-1:0] exp_be(logic store, int size, int off);
		logic [BE_W-1:0] be;
		for (int b = 0; b < BE_W; b++) begin
			be[b] = !store || ((b >= off) && (b < off + size));
		end
		return be;
	endfunction

	task automatic report_error(string what);
		errors++;
		$display("ERROR: %0s at cycle %0d", what, cycle);
	endtask

	task automatic check_ins(logic [XLEN-1:0] got_ins, logic [XLEN-1:0] got_pc,
			logic [XLEN-1:0] want_ins, logic [XLEN-1:0] want_pc);
		checks++;
		if (got_pc !== want_pc) begin
			errors++;
			$display("CHECK FAILED pc_o got %h expected %h", got_pc, want_pc);
		end else if (got_ins !== want_ins) begin
			errors++;
			$display("CHECK FAILED ins_o pc %h got %h expected %h", got_pc, got_ins, want_ins);
		end
	endtask

	task automatic check_done(logic [XLEN-1:0] got_data, logic got_raised,
			except_code_t got_code, logic [XLEN-1:0] want_data, except_code_t want_code);
		logic want_raised;
		want_raised = (want_code != E_NONE);
		checks++;
		if (got_raised !== want_raised) begin
			errors++;
			$display("CHECK FAILED except_raised_o got %h expected %h",
				got_raised, want_raised);
		end
		if (got_code !== want_code) begin
			errors++;
			$display("CHECK FAILED except_code_o got %h expected %h", got_code, want_code);
		end
		if (got_data !== want_data) begin
			errors++;
			$display("CHECK FAILED ld_data_o got %h expected %h", got_data, want_data);
		end
	endtask

	task automatic check_l2_req(logic [XLEN-1:0] got_addr, logic got_we,
			logic [BE_W-1:0] got_be, logic [XLEN-1:0] want_addr, logic want_we,
			logic [BE_W-1:0] want_be);
		checks++;
		if ((got_addr !== want_addr) || (got_we !== want_we) || (got_be !== want_be)) begin
			errors++;
			$display("CHECK FAILED l2_req_addr_o/we/be got %h/%h/%h expected %h/%h/%h",
				got_addr, got_we, got_be, want_addr, want_we, want_be);
		end
	endtask

	// Expectations for an op as it is accepted
	task automatic record_op(ldst_type_t t, logic [XLEN-1:0] a, logic [XLEN-1:0] wd);
		logic            store;
		logic            misal;
		logic [BE_W-1:0] be;
		int              size;
		int              wi;
		store = (t == SB) || (t == SH) || (t == SW);
		size  = access_size(t);
		// Naturally aligned means offset is a multiple of the size
		misal = (int'(a[1:0]) % size) != 0;
		wi    = int'(a[12:2]);
		exp_data = '0;
		if (misal) begin
			exp_code = store ? E_ST_MISALIGN : E_LD_MISALIGN;
		end else begin
			exp_code  = E_NONE;
			be        = exp_be(store, size, int'(a[1:0]));
			dreq_pend = 1'b1;
			dreq_addr = {a[XLEN-1:2], 2'b00};
			dreq_we   = store;
			dreq_be   = be;
			if (store) begin
				// Low bytes of the store data land from the addressed lane up
				for (int b = 0; b < BE_W; b++) begin
					if (be[b]) begin
						ref_mem[wi][8*b +: 8] = wd[8*(b - int'(a[1:0])) +: 8];
					end
				end
			end else begin
				exp_data = exp_load(ref_mem[wi], a, t);
			end
		end
	endtask

	// L2 model with random ready and 1 to 4 cycles of latency
	always @(posedge clk_i) begin : l2_model
		logic [31:0] r;
		int          d;
		int          wi;
		cycle = cycle + 1;
		r = $random(seed);
		l2_req_rdy_i <= r[0];
		ins_ready_i  <= r[1];
		done_ready_i <= r[2] | r[3];
		if (!rst_i && l2_req_valid_o && l2_req_rdy_i) begin
			wi = int'(l2_req_addr_o[12:2]);
			if (l2_req_we_o) begin
				for (int b = 0; b < BE_W; b++) begin
					if (l2_req_be_o[b]) begin
						mem[wi][8*b +: 8] = l2_req_wdata_o[8*b +: 8];
					end
				end
				ans_q.push_back('0);
			end else begin
				ans_q.push_back(mem[wi]);
			end
			src_q.push_back(l2_req_src_o);
			d = cycle + 1 + int'(r[5:4]);
			// Answers stay in request order
			if (d <= last_due) begin
				d = last_due + 1;
			end
			last_due = d;
			due_q.push_back(d);
		end
		if ((due_q.size() > 0) && (due_q[0] == cycle)) begin
			l2_ans_valid_i <= 1'b1;
			l2_ans_rdata_i <= ans_q.pop_front();
			l2_ans_src_i   <= src_q.pop_front();
			void'(due_q.pop_front());
		end else begin
			l2_ans_valid_i <= 1'b0;
		end
	end

	always @(posedge clk_i) begin : compare
		if (!rst_i) begin
			if (l2_req_valid_o && l2_req_rdy_i) begin
				if (l2_req_src_o == SRC_DATA) begin
					if (!dreq_pend) begin
						report_error("data request on the L2 port with no aligned op waiting");
					end else begin
						check_l2_req(l2_req_addr_o, l2_req_we_o, l2_req_be_o,
							dreq_addr, dreq_we, dreq_be);
					end
					dreq_pend = 1'b0;
				end else if (old_pend && (l2_req_addr_o === old_addr)) begin
					// Raised before the redirect, still goes out once
					check_l2_req(l2_req_addr_o, l2_req_we_o, l2_req_be_o,
						old_addr, 1'b0, '1);
					old_pend = 1'b0;
				end else begin
					// Fetch is a plain word read along the PC stream
					check_l2_req(l2_req_addr_o, l2_req_we_o, l2_req_be_o,
						fetch_addr, 1'b0, '1);
					fetch_addr = fetch_addr + 'd4;
					old_pend   = 1'b0;
				end
			end
			if (ins_valid_o && ins_ready_i) begin
				check_ins(ins_o, pc_o, ref_mem[exp_pc[12:2]], exp_pc);
				exp_pc = exp_pc + 'd4;
				ins_count++;
			end
			// Redirect takes effect after any handshake of the same edge
			if (flush_i) begin
				exp_pc     = flush_pc_i;
				old_addr   = fetch_addr;
				old_pend   = 1'b1;
				fetch_addr = flush_pc_i;
			end
			if (op_valid_i && op_ready_o) begin
				record_op(op_type_i, op_addr_i, op_wdata_i);
			end
			if (done_valid_o && done_ready_i) begin
				check_done(ld_data_o, except_raised_o, except_code_o, exp_data, exp_code);
				done_count++;
			end
		end
	end

	task automatic run_op(ldst_type_t t, logic [XLEN-1:0] a, logic [XLEN-1:0] wd);
		int target;
		target = done_count + 1;
		op_valid_i <= 1'b1;
		op_type_i  <= t;
		op_addr_i  <= a;
		op_wdata_i <= wd;
		do begin
			@(posedge clk_i);
		end while (!op_ready_o);
		op_valid_i <= 1'b0;
		while (done_count < target) begin
			@(posedge clk_i);
		end
	endtask

	task automatic wait_ins(int n);
		int target;
		target = ins_count + n;
		while (ins_count < target) begin
			@(posedge clk_i);
		end
	endtask

	// Redirect while a fetch request is raised
	task automatic flush_to(logic [XLEN-1:0] pc);
		do begin
			@(posedge clk_i);
		end while (!(l2_req_valid_o && (l2_req_src_o == SRC_FETCH)));
		flush_i    <= 1'b1;
		flush_pc_i <= pc;
		@(posedge clk_i);
		flush_i    <= 1'b0;
	endtask

	task automatic end_test(string name);
		$display("test %0s finished, errors so far %0d", name, errors);
	endtask

	initial begin
		seed     = 32'hc96d_9d3f;
		#(8 * (N_OPS * 20 + 200));
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : stimulus
		logic [31:0]     r;
		logic [XLEN-1:0] a;
		rst_i          = 1'b1;
		flush_i        = 1'b0;
		flush_pc_i     = '0;
		ins_ready_i    = 1'b0;
		op_valid_i     = 1'b0;
		op_type_i      = LW;
		op_addr_i      = '0;
		op_wdata_i     = '0;
		done_ready_i   = 1'b0;
		l2_req_rdy_i   = 1'b0;
		l2_ans_valid_i = 1'b0;
		l2_ans_rdata_i = '0;
		l2_ans_src_i   = SRC_FETCH;
		cycle      = 0;
		last_due   = 0;
		exp_pc     = BOOT;
		exp_code   = E_NONE;
		exp_data   = '0;
		dreq_pend  = 1'b0;
		fetch_addr = BOOT;
		old_addr   = '0;
		old_pend   = 1'b0;
		ins_count  = 0;
		done_count = 0;
		checks     = 0;
		errors     = 0;
		// Every byte lane has its sign bit set
		for (int i = 0; i < MEM_W; i++) begin
			mem[i]     = ((i * 32'h9e37_79b1) ^ 32'h1357_9bdf) | 32'h8080_8080;
			ref_mem[i] = mem[i];
		end
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;

		wait_ins(20);
		end_test("sequential fetch");

		for (int i = 0; i < 4; i++) begin
			flush_to(BOOT + XLEN'(64 * (i + 1)));
			wait_ins(6);
		end
		end_test("flush");

		for (int w = 0; w < 2; w++) begin
			for (int off = 0; off < 4; off++) begin
				a = DBASE + XLEN'(4 * w + off);
				run_op(LB, a, '0);
				run_op(LBU, a, '0);
				if (off % 2 == 0) begin
					run_op(LH, a, '0);
					run_op(LHU, a, '0);
				end
				if (off == 0) begin
					run_op(LW, a, '0);
				end
			end
		end
		end_test("loads");

		for (int off = 0; off < 4; off++) begin
			r = $random(seed);
			run_op(SB, DBASE + XLEN'('h40 + off), r);
			run_op(LW, DBASE + XLEN'('h40), '0);
		end
		for (int off = 0; off < 4; off += 2) begin
			r = $random(seed);
			run_op(SH, DBASE + XLEN'('h44 + off), r);
			run_op(LW, DBASE + XLEN'('h44), '0);
		end
		r = $random(seed);
		run_op(SW, DBASE + XLEN'('h48), r);
		run_op(LW, DBASE + XLEN'('h48), '0);
		end_test("stores");

		run_op(LH, DBASE + XLEN'(1), '0);
		run_op(LH, DBASE + XLEN'(3), '0);
		run_op(SH, DBASE + XLEN'(1), 'h1234);
		run_op(SH, DBASE + XLEN'(3), 'h1234);
		for (int off = 1; off < 4; off++) begin
			run_op(LW, DBASE + XLEN'(off), '0);
			run_op(SW, DBASE + XLEN'(off), 'hdead_beef);
		end
		end_test("misalignment");

		flush_to(BOOT);
		for (int i = 0; i < 60; i++) begin
			r = $random(seed);
			a = DBASE + XLEN'(r[15:8]);
			run_op(ldst_type_t'(r[2:0]), a, $random(seed));
		end
		end_test("concurrency");

		repeat (10) @(posedge clk_i);
		$display("Summary: %0d checks, %0d errors, %0d instructions, %0d ops",
			checks, errors, ins_count, done_count);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== data_path_memory.f ====
mem_pkg.sv
l2_chan_if.sv
ifetch_unit.sv
ldst_unit.sv
l2_arbiter.sv
data_path_memory.sv
data_path_memory_chk.sv
data_path_memory_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module data_path_memory_tb \
	-f data_path_memory.f \
	-o data_path_memory_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/data_path_memory_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
echo "Pass message not found"
exit 1
